//--- Makefile
VERILATOR = verilator
TOP = bannerTb
RTL_TOP = bannerTop
FILELIST = project.f
OBJ_DIR = obj_dir
FLAGS = --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS = --lint-only -Wall --timing --assert --timescale 1ns/10ps
PASS_TEXT = === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- project.f
+incdir+verilog
verilog/bannerPkg.sv
verilog/videoTiming.sv
verilog/glyphRom.sv
verilog/letterLayer.sv
verilog/frameLayer.sv
verilog/pixelMixer.sv
verilog/bannerTop.sv
tests/bannerTb.sv

//--- tests/bannerTb.sv
`timescale 1ns/10ps

module bannerTb;
	import bannerPkg::*;

	// The ROM has already expanded the table once in this compilation unit
`undef GLYPH_BITS_SVH
`include "glyphBits.svh"

	localparam int frameClocks = hTotal * vTotal;
	// Four frames at full rate, one at half rate and a few lines before the reset
	localparam int testCycles = 6 * frameClocks + 4 * hTotal;
	localparam int cycleLimit = testCycles + testCycles / 8;

	logic clk = 1'b0;
	logic rstN = 1'b0;
	logic pixEn = 1'b0;
	logic [colorW-1:0] textColor = '0;
	logic [colorW-1:0] frameColor = '0;
	logic [colorW-1:0] rgb;
	logic hSync;
	logic vSync;

	logic gapMode = 1'b0;   // Strobe only on every other clock
	logic checking = 1'b0;  // Compare on every clock once reset is over
	int cycles = 0;
	int colorErrors = 0;
	int syncErrors = 0;
	int otherErrors = 0;

	// Model counters and the two positions in flight towards the outputs
	int mx;
	int my;
	int aX;
	int aY;
	int bX;
	int bY;
	int outX;  // Position shown at the outputs, -1 while the pipeline is idle
	int outY;
	logic [colorW-1:0] expRgb;
	logic expH;
	logic expV;

	bannerTop i_bannerTop (
		.clk        (clk),
		.rstN       (rstN),
		.pixEn      (pixEn),
		.textColor  (textColor),
		.frameColor (frameColor),
		.rgb        (rgb),
		.hSync      (hSync),
		.vSync      (vSync)
	);

	always #2 clk = !clk;

	always @(posedge clk)
	begin
		#0.5;
		pixEn = gapMode ? !pixEn : 1'b1;  // Toggling gives one step per two clocks
	end

	// Glyph bit of a screen position, found by walking the slot table
	function automatic logic letterBit(int px, int py);
		int rx;
		int ry;
		rx = px - originX;
		ry = py - originY;
		if (px < 0 || px >= hActive || py >= vActive || ry < 0 || ry >= glyphRows)
			return 1'b0;
		for (int i = 0; i < slotCount; i++)
		begin
			if (rx >= slotStart[i] && rx <= slotEnd[i])
				return glyphBits[i][ry][rx - slotStart[i]];
		end
		return 1'b0;
	endfunction

	function automatic logic frameBit(int px, int py);
		int left;
		int right;
		int top;
		int bottom;
		left = originX - frameMargin;
		right = originX + bannerLastCol + frameMargin;
		top = originY - frameMargin;
		bottom = originY + glyphRows - 1 + frameMargin;
		if (px < left || px > right || py < top || py > bottom)
			return 1'b0;
		return (px == left || px == right || py == top || py == bottom);
	endfunction

	function automatic logic [colorW-1:0] pixelColor(int px, int py,
		logic [colorW-1:0] tc, logic [colorW-1:0] fc);
		if (px < 0 || px >= hActive || py >= vActive)
			return '0;  // Blanking
		if (letterBit(px, py))
			return tc;
		if (frameBit(px, py))
			return fc;
		return '0;
	endfunction

	// Reference scan, three clocks from counter to outputs
	always @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			mx <= 0;
			my <= 0;
			aX <= -1;
			aY <= -1;
			bX <= -1;
			bY <= -1;
			outX <= -1;
			outY <= -1;
			expRgb <= '0;
			expH <= 1'b1;
			expV <= 1'b1;
		end
		else
		begin
			aX <= mx;
			aY <= my;
			bX <= aX;
			bY <= aY;
			outX <= bX;
			outY <= bY;
			expRgb <= pixelColor(bX, bY, textColor, frameColor);  // Colours as of this edge
			expH <= !(bX >= hActive + hFront && bX < hActive + hFront + hSyncLen);
			expV <= !(bY >= vActive + vFront && bY < vActive + vFront + vSyncLen);
			if (pixEn)
			begin
				mx <= (mx == hTotal - 1) ? 0 : mx + 1;
				if (mx == hTotal - 1)
					my <= (my == vTotal - 1) ? 0 : my + 1;
			end
		end
	end

	task automatic checkColor(string name, logic [colorW-1:0] got, logic [colorW-1:0] exp);
		if (got !== exp)
		begin
			colorErrors++;
			$display("mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	task automatic checkSync(string name, logic got, logic exp);
		if (got !== exp)
		begin
			syncErrors++;
			$display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, got);
		end
	endtask

	task automatic reportFailure(string what);
		otherErrors++;
		$display("error at %0t: %s", $time, what);
	endtask

	always @(negedge clk)
	begin
		if (checking)
		begin
			checkColor("rgb", rgb, expRgb);
			checkSync("hSync", hSync, expH);
			checkSync("vSync", vSync, expV);
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("timeout: tests still running after %0d clocks", cycleLimit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic nextEdge();
		@(posedge clk);
		#0.5;
	endtask

	// Waits on falling edges until the outputs show the given position
	task automatic waitOutputAt(int wx, int wy);
		@(negedge clk);
		while (outX != wx || outY != wy)
			@(negedge clk);
	endtask

	task automatic syncAndBlanking();
		int hLow;
		int vLow;
		hLow = 0;
		vLow = 0;
		nextEdge();
		textColor = colorW'(7);
		frameColor = colorW'(7);
		waitOutputAt(0, 0);
		for (int n = 0; n < frameClocks; n++)
		begin
			if (n > 0)
				@(negedge clk);
			hLow += !hSync;
			vLow += !vSync;
			if (outX >= hActive || outY >= vActive)
				checkColor("rgb", rgb, '0);  // Both colours at 7 must still blank
		end
		if (hLow != vTotal * hSyncLen)
			reportFailure($sformatf("hSync was low for %0d clocks in one frame", hLow));
		if (vLow != vSyncLen * hTotal)
			reportFailure($sformatf("vSync was low for %0d clocks in one frame", vLow));
	endtask

	task automatic lettersInSlots();
		int lit;
		int want;
		int rx;
		int ry;
		lit = 0;
		want = 0;
		for (int s = 0; s < slotCount; s++)
			for (int r = 0; r < glyphRows; r++)
				want += $countones(glyphBits[s][r]);
		nextEdge();
		textColor = colorW'(1 + $urandom % 7);
		frameColor = '0;
		waitOutputAt(0, 0);
		for (int n = 0; n < frameClocks; n++)
		begin
			if (n > 0)
				@(negedge clk);
			rx = outX - originX;
			ry = outY - originY;
			// Covers the slots, the gaps and the missing eighth column of slot 6
			if (ry >= 0 && ry < glyphRows && rx >= 0 && rx <= bannerLastCol + 1)
			begin
				if (letterBit(outX, outY))
					checkColor("rgb", rgb, textColor);
				else
					checkColor("rgb", rgb, '0);
				if (rgb === textColor)
					lit++;  // Lit pixels as the DUT shows them
			end
		end
		if (lit != want)
			reportFailure($sformatf("saw %0d letter pixels instead of %0d", lit, want));
	endtask

	task automatic outlineAndPriority();
		int edges;
		int want;
		logic inRect;
		edges = 0;
		want = 2 * (bannerLastCol + 1 + 2 * frameMargin) + 2 * (glyphRows + 2 * frameMargin) - 4;
		nextEdge();
		textColor = colorW'(1 + $urandom % 7);  // New colours land in the frame gap
		frameColor = colorW'(1 + $urandom % 7);
		waitOutputAt(0, 0);
		for (int n = 0; n < frameClocks; n++)
		begin
			if (n > 0)
				@(negedge clk);
			inRect = outX > originX - frameMargin && outX < originX + bannerLastCol + frameMargin
				&& outY > originY - frameMargin && outY < originY + glyphRows - 1 + frameMargin;
			if (frameBit(outX, outY))
				checkColor("rgb", rgb, frameColor);
			else if (inRect && !letterBit(outX, outY))
				checkColor("rgb", rgb, '0);
			// Outline pixels anywhere on screen as the DUT draws them
			if (rgb === frameColor && !letterBit(outX, outY))
				edges++;
		end
		if (edges != want)
			reportFailure($sformatf("saw %0d outline pixels instead of %0d", edges, want));
	endtask

	task automatic strobeGaps();
		int hLow;
		int vLow;
		hLow = 0;
		vLow = 0;
		gapMode = 1'b1;
		waitOutputAt(0, 0);
		// At half rate every sync position is shown for two clocks
		for (int n = 0; n < 2 * frameClocks; n++)
		begin
			if (n > 0)
				@(negedge clk);
			hLow += !hSync;
			vLow += !vSync;
		end
		gapMode = 1'b0;
		if (hLow != 2 * vTotal * hSyncLen)
			reportFailure($sformatf("hSync was low for %0d clocks in a half-rate frame", hLow));
		if (vLow != 2 * vSyncLen * hTotal)
			reportFailure($sformatf("vSync was low for %0d clocks in a half-rate frame", vLow));
	endtask

	task automatic resetMidFrame();
		int clocksToSync;
		clocksToSync = 0;
		repeat (2 * hTotal + 300)
			nextEdge();
		rstN = 1'b0;  // Lands in the middle of line 2
		repeat (5)
		begin
			@(negedge clk);
			checkColor("rgb", rgb, '0);
			checkSync("hSync", hSync, 1'b1);
			checkSync("vSync", vSync, 1'b1);
		end
		nextEdge();
		rstN = 1'b1;
		// Counter holds 0,0 until the first rising edge after the release
		@(negedge clk);
		// First sync pulse shows where the restarted counter is
		while (hSync)
		begin
			@(negedge clk);
			clocksToSync++;
		end
		if (clocksToSync != 3 + hActive + hFront)
			reportFailure($sformatf("first hSync after reset came after %0d clocks",
				clocksToSync));
		waitOutputAt(hTotal - 1, vTotal - 1);
	endtask

	initial
	begin
		int totalErrors;
		void'($urandom(32'h0711_be09));
		repeat (5)
			nextEdge();
		rstN = 1'b1;
		checking = 1'b1;
		syncAndBlanking();
		lettersInSlots();
		outlineAndPriority();
		strobeGaps();
		resetMidFrame();
		totalErrors = colorErrors + syncErrors + otherErrors;
		$display("errors: %0d rgb, %0d sync, %0d other", colorErrors, syncErrors, otherErrors);
		if (totalErrors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- verilog/bannerPkg.sv
package bannerPkg;

	// Horizontal timing in pixel clocks for 640x480 at 60 Hz
	localparam int hActive = 640;
	localparam int hFront = 16;
	localparam int hSyncLen = 96;
	localparam int hBack = 48;
	localparam int hTotal = hActive + hFront + hSyncLen + hBack;  // 800 clocks per line

	// Vertical timing in lines
	localparam int vActive = 480;
	localparam int vFront = 10;
	localparam int vSyncLen = 2;
	localparam int vBack = 33;
	localparam int vTotal = vActive + vFront + vSyncLen + vBack;  // 525 lines per frame

	localparam int coordW = 10;  // Holds any count up to hTotal-1
	localparam int colorW = 3;   // One bit per gun in R, G, B order

	// Top-left pixel of the banner box
	localparam int originX = 288;
	localparam int originY = 232;

	// Glyph geometry of the font ROM
	localparam int glyphRows = 16;
	localparam int glyphCols = 8;
	localparam int rowW = $clog2(glyphRows);  // Row index into one glyph
	localparam int colW = $clog2(glyphCols);  // Bit index into one ROM word

	// Six letter slots, code 0 is reserved for "no letter"
	localparam int slotCount = 6;
	localparam int slotW = 3;

	// Slot bounds in columns relative to originX
	// The last slot is only seven columns wide
	localparam int slotStart [slotCount] = '{0, 8, 23, 31, 46, 54};
	localparam int slotEnd [slotCount] = '{7, 15, 30, 38, 53, 60};

	// Banner box spans columns 0 to bannerLastCol and rows 0 to glyphRows-1
	localparam int bannerLastCol = 60;

	localparam int frameMargin = 4;  // Outline sits this far outside the banner box

endpackage

//--- verilog/bannerTop.sv
`timescale 1ns/10ps

module bannerTop (
	input  logic clk,
	input  logic rstN,
	input  logic pixEn,                               // Pixel strobe from the external divider
	input  logic [bannerPkg::colorW-1:0] textColor,
	input  logic [bannerPkg::colorW-1:0] frameColor,
	output logic [bannerPkg::colorW-1:0] rgb,         // Three clocks behind the counters
	output logic hSync,
	output logic vSync
);
	import bannerPkg::*;

	logic [coordW-1:0] x;
	logic [coordW-1:0] y;
	logic active;
	logic hSyncRaw;
	logic vSyncRaw;
	logic letterOn;
	logic frameOn;

	videoTiming i_videoTiming (
		.clk      (clk),
		.rstN     (rstN),
		.pixEn    (pixEn),
		.x        (x),
		.y        (y),
		.active   (active),
		.hSyncRaw (hSyncRaw),
		.vSyncRaw (vSyncRaw)
	);

	// Both layers look at the same beam position in parallel
	letterLayer i_letterLayer (
		.clk      (clk),
		.rstN     (rstN),
		.x        (x),
		.y        (y),
		.active   (active),
		.letterOn (letterOn)
	);

	frameLayer i_frameLayer (
		.clk     (clk),
		.rstN    (rstN),
		.x       (x),
		.y       (y),
		.active  (active),
		.frameOn (frameOn)
	);

	pixelMixer i_pixelMixer (
		.clk        (clk),
		.rstN       (rstN),
		.letterOn   (letterOn),
		.frameOn    (frameOn),
		.active     (active),
		.hSyncRaw   (hSyncRaw),
		.vSyncRaw   (vSyncRaw),
		.textColor  (textColor),
		.frameColor (frameColor),
		.rgb        (rgb),
		.hSync      (hSync),
		.vSync      (vSync)
	);

endmodule

//--- verilog/frameLayer.sv
`timescale 1ns/10ps

module frameLayer (
	input  logic clk,
	input  logic rstN,
	input  logic [bannerPkg::coordW-1:0] x,
	input  logic [bannerPkg::coordW-1:0] y,
	input  logic active,
	output logic frameOn   // Outline bit, aligned with letterOn
);
	import bannerPkg::*;

	logic [coordW-1:0] left;    // Outline edges in screen coordinates
	logic [coordW-1:0] right;
	logic [coordW-1:0] top;
	logic [coordW-1:0] bottom;
	logic inBox;                // Inside or on the outline rectangle
	logic onEdge;
	logic frameQ;               // First pipeline stage

	assign left = coordW'(originX - frameMargin);
	assign right = coordW'(originX + bannerLastCol + frameMargin);
	assign top = coordW'(originY - frameMargin);
	assign bottom = coordW'(originY + glyphRows - 1 + frameMargin);

	assign inBox = (x >= left) && (x <= right) && (y >= top) && (y <= bottom);

	// One pixel wide border of the rectangle
	assign onEdge = active && inBox &&
		((x == left) || (x == right) || (y == top) || (y == bottom));

	// Two stages match the slot register and the ROM read of the letter layer
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			frameQ <= 1'b0;
			frameOn <= 1'b0;
		end
		else
		begin
			frameQ <= onEdge;
			frameOn <= frameQ;
		end
	end

endmodule

//--- verilog/glyphBits.svh
`ifndef GLYPH_BITS_SVH
`define GLYPH_BITS_SVH

// Bitmaps of the six banner letters, one word per glyph row
// Bit c of each word is screen column c counted from the slot's left edge
// So every literal reads mirrored compared to the picture on screen
// Outer index is slot code minus one, inner index is the row
localparam logic [bannerPkg::glyphCols-1:0] glyphBits
	[bannerPkg::slotCount][bannerPkg::glyphRows] = '{
	// Slot 1 J with a hook at the bottom left
	'{8'h00, 8'h00, 8'h7e, 8'h30, 8'h30, 8'h30, 8'h30, 8'h30,
	  8'h30, 8'h30, 8'h30, 8'h33, 8'h33, 8'h1e, 8'h00, 8'h00},
	// Slot 2 V
	'{8'h00, 8'h00, 8'hc3, 8'hc3, 8'hc3, 8'hc3, 8'hc3, 8'hc3,
	  8'hc3, 8'hc3, 8'h66, 8'h66, 8'h3c, 8'h18, 8'h00, 8'h00},
	// Slot 3 M
	'{8'h00, 8'h00, 8'hc3, 8'he7, 8'hff, 8'hdb, 8'hc3, 8'hc3,
	  8'hc3, 8'hc3, 8'hc3, 8'hc3, 8'hc3, 8'hc3, 8'h00, 8'h00},
	// Slot 4 B
	'{8'h00, 8'h00, 8'h3f, 8'hc3, 8'hc3, 8'hc3, 8'hc3, 8'h3f,
	  8'hc3, 8'hc3, 8'hc3, 8'hc3, 8'hc3, 8'h3f, 8'h00, 8'h00},
	// Slot 5 S
	'{8'h00, 8'h00, 8'h7e, 8'h03, 8'h03, 8'h03, 8'h03, 8'h7e,
	  8'hc0, 8'hc0, 8'hc0, 8'hc0, 8'hc0, 8'h7e, 8'h00, 8'h00},
	// Slot 6 L, bit 7 stays clear since the slot is seven columns wide
	'{8'h00, 8'h00, 8'h03, 8'h03, 8'h03, 8'h03, 8'h03, 8'h03,
	  8'h03, 8'h03, 8'h03, 8'h03, 8'h03, 8'h7f, 8'h00, 8'h00}
};

`endif

//--- verilog/glyphRom.sv
`timescale 1ns/10ps

module glyphRom (
	input  logic clk,
	input  logic [bannerPkg::slotW-1:0] slot,      // Letter code, 0 means blank
	input  logic [bannerPkg::rowW-1:0] row,        // Row inside the glyph
	output logic [bannerPkg::glyphCols-1:0] word   // One glyph row, bit 0 on the left
);
	import bannerPkg::*;

`include "glyphBits.svh"

	logic slotValid;  // Codes 1 to slotCount address a glyph

	assign slotValid = (slot != '0) && (slot <= slotW'(slotCount));

	// Synchronous read every clock so the word lines up with the next stage
	always_ff @(posedge clk)
	begin
		if (slotValid)
			word <= glyphBits[slot - 1'b1][row];
		else
			word <= '0;  // Blank slot code and unused codes read as empty
	end

endmodule

//--- verilog/letterLayer.sv
`timescale 1ns/10ps

module letterLayer (
	input  logic clk,
	input  logic rstN,
	input  logic [bannerPkg::coordW-1:0] x,
	input  logic [bannerPkg::coordW-1:0] y,
	input  logic active,
	output logic letterOn   // Glyph bit of the pixel, two edges after x and y
);
	import bannerPkg::*;

	logic [coordW-1:0] relX;  // Beam column measured from the banner origin
	logic [coordW-1:0] relY;  // Beam line measured from the banner origin
	logic [slotW-1:0] slotNext;
	logic [colW-1:0] colNext;
	logic [slotW-1:0] slotQ;
	logic [rowW-1:0] rowQ;
	logic [colW-1:0] colQ;
	logic [colW-1:0] colQ2;   // Column held one more stage to meet the ROM word
	logic [glyphCols-1:0] word;

	// Left of or above the banner these wrap to large values and miss every slot
	assign relX = x - coordW'(originX);
	assign relY = y - coordW'(originY);

	// Priority search over the slot table, the first slot that matches wins
	always_comb
	begin
		logic found;
		found = 1'b0;
		slotNext = '0;
		colNext = '0;
		for (int i = 0; i < slotCount; i++)
		begin
			if (!found && relX >= coordW'(slotStart[i]) && relX <= coordW'(slotEnd[i]))
			begin
				found = 1'b1;
				slotNext = slotW'(i + 1);  // Codes count from 1
				colNext = colW'(relX - coordW'(slotStart[i]));
			end
		end
		if (!active || relY > coordW'(glyphRows - 1))
			slotNext = '0;  // Outside the banner rows or in blanking
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			slotQ <= '0;
		else
			slotQ <= slotNext;
	end

	// Row and column only matter when the slot code is non-zero
	always_ff @(posedge clk)
	begin
		rowQ <= relY[rowW-1:0];
		colQ <= colNext;
		colQ2 <= colQ;
	end

	glyphRom i_glyphRom (
		.clk  (clk),
		.slot (slotQ),
		.row  (rowQ),
		.word (word)
	);

	assign letterOn = word[colQ2];  // A blank slot reads zero so this stays dark

endmodule

//--- verilog/pixelMixer.sv
`timescale 1ns/10ps

module pixelMixer (
	input  logic clk,
	input  logic rstN,
	input  logic letterOn,
	input  logic frameOn,
	input  logic active,                              // Straight from the timing generator
	input  logic hSyncRaw,
	input  logic vSyncRaw,
	input  logic [bannerPkg::colorW-1:0] textColor,   // Switch inputs for the letters
	input  logic [bannerPkg::colorW-1:0] frameColor,  // Switch inputs for the outline
	output logic [bannerPkg::colorW-1:0] rgb,
	output logic hSync,
	output logic vSync
);
	import bannerPkg::*;

	logic activeD1;
	logic activeD2;   // Lines up with letterOn and frameOn
	logic hSyncD1;
	logic hSyncD2;
	logic vSyncD1;
	logic vSyncD2;
	logic [colorW-1:0] pixColor;

	// Two stages of delay matching the layer pipelines, syncs idle high
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			activeD1 <= 1'b0;
			activeD2 <= 1'b0;
			hSyncD1 <= 1'b1;
			hSyncD2 <= 1'b1;
			vSyncD1 <= 1'b1;
			vSyncD2 <= 1'b1;
		end
		else
		begin
			activeD1 <= active;
			activeD2 <= activeD1;
			hSyncD1 <= hSyncRaw;
			hSyncD2 <= hSyncD1;
			vSyncD1 <= vSyncRaw;
			vSyncD2 <= vSyncD1;
		end
	end

	// Letters sit on top of the outline and blanking overrides both
	always_comb
	begin
		if (!activeD2)
			pixColor = '0;
		else if (letterOn)
			pixColor = textColor;
		else if (frameOn)
			pixColor = frameColor;
		else
			pixColor = '0;  // Background is black
	end

	// Output stage, the third clock of the total latency
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			rgb <= '0;
			hSync <= 1'b1;
			vSync <= 1'b1;
		end
		else
		begin
			rgb <= pixColor;
			hSync <= hSyncD2;
			vSync <= vSyncD2;
		end
	end

	// A blanked pixel must leave the output stage black on the next clock
	assert property (@(posedge clk) disable iff (!rstN) !activeD2 |=> rgb == '0)
		else $error("pixelMixer drove rgb=%0h during blanking", rgb);

endmodule

//--- verilog/videoTiming.sv
`timescale 1ns/10ps

module videoTiming (
	input  logic clk,
	input  logic rstN,
	input  logic pixEn,                         // One pixel step per strobe
	output logic [bannerPkg::coordW-1:0] x,     // Column of the current pixel
	output logic [bannerPkg::coordW-1:0] y,     // Line of the current pixel
	output logic active,
	output logic hSyncRaw,                      // Active low
	output logic vSyncRaw                       // Active low
);
	import bannerPkg::*;

	logic lineEnd;   // Last column of a line
	logic frameEnd;  // Last line of a frame

	assign lineEnd = (x == coordW'(hTotal - 1));
	assign frameEnd = (y == coordW'(vTotal - 1));

	// Horizontal counter steps only on the strobe and wraps at the end of a line
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			x <= '0;
		else if (pixEn)
		begin
			if (lineEnd)
				x <= '0;
			else
				x <= x + 1'b1;
		end
	end

	// Vertical counter moves once per wrap of the horizontal one
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			y <= '0;
		else if (pixEn && lineEnd)
		begin
			if (frameEnd)
				y <= '0;
			else
				y <= y + 1'b1;
		end
	end

	// Visible area is the top-left corner of the full scan
	assign active = (x < coordW'(hActive)) && (y < coordW'(vActive));

	// Sync pulses start right after the front porch
	assign hSyncRaw = !((x >= coordW'(hActive + hFront)) &&
		(x < coordW'(hActive + hFront + hSyncLen)));
	assign vSyncRaw = !((y >= coordW'(vActive + vFront)) &&
		(y < coordW'(vActive + vFront + vSyncLen)));

	// Both counters must wrap before their totals
	assert property (@(posedge clk) disable iff (!rstN) x < coordW'(hTotal))
		else $error("videoTiming x reached %0d", x);
	assert property (@(posedge clk) disable iff (!rstN) y < coordW'(vTotal))
		else $error("videoTiming y reached %0d", y);

endmodule
